// ==== sources.f ====
source/px_state_pkg.sv
source/px_bus_pkg.sv
source/px_state_register.sv
source/px_delay_timer.sv
source/px_strobe_sequencer.sv
source/px_bus_requester.sv
source/px_control.sv
bench/px_clock_gen.sv
bench/px_control_tb.sv

// ==== bench/px_control_tb.sv ====
/*
	P-X state control testbench
	Random enter requests, bus responder, reference timing and state checks
*/
`timescale 1ns/1ps

module px_control_tb
	import px_state_pkg::*, px_bus_pkg::*;
();

	localparam int N_RUN = 80;	// State changes checked
	localparam int SEED = 51116;
	localparam int WORST_CYC = 8 + 3 * (4 + RETRY_GAP) + ALARM_TICKS + 1 + 8;	// Longest state
	localparam int TIMEOUT_NS = (N_RUN + 4) * WORST_CYC * 20;

	logic      got;
	logic      clo;
	state_word enter;
	logic      mode;
	logic      step;
	logic      rok;
	logic      ren;
	state_word state;
	logic      strob1;
	logic      strob2;
	logic      zg;
	logic      awaria;

	int stim_seed = SEED;
	int resp_seed = SEED + 1;	// Responder stream
	int step_seed = SEED + 2;	// Step pulse stream
	int bus_extra;	// Bus cycles of the current state
	bit alarm_exp;	// Responder stayed silent once

	task automatic check(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("ERROR at %0t: %s is %0h, expected %0h", $time, name, actual, expected);
			$display("TESTBENCH FAILED");
			$fatal(1, "Mismatch on %s", name);
		end
	endtask

	// Lowest requested state wins, P0 when nothing is requested
	function automatic state_word lowest_request(state_word req);
		for (int i = 0; i < N_STATES; i++)
			if (req[i])
				return state_word'(1) << i;
		return state_word'(1) << ST_P0;
	endfunction

	// Cycles from strob2 to strob1 for a state
	function automatic int strob1_offset(int idx, int bus_cyc, logic step_mode,
		logic [255:0] steps);
		int ready;
		ready = GROUP_LEN[STATE_GROUP[idx]] + 2 + bus_cyc;	// Delay, done and bus cycle
		if (!step_mode)
			return ready;
		for (int c = ready; c < 255; c++)
			if (steps[c])
				return c + 1;	// First step once the state is ready
		return -1;
	endfunction

	function automatic int state_index(state_word s);
		for (int i = 0; i < N_STATES; i++)
			if (s[i])
				return i;
		return 0;
	endfunction

	px_clock_gen #(.PERIOD(20)) u_clock (.got(got));

	px_control UUT (
		.got    (got),
		.clo    (clo),
		.enter  (enter),
		.mode   (mode),
		.step   (step),
		.rok    (rok),
		.ren    (ren),
		.state  (state),
		.strob1 (strob1),
		.strob2 (strob2),
		.zg     (zg),
		.awaria (awaria)
	);

	initial begin : stimulus
		int k;
		clo = 1'b1;
		enter = '0;
		mode = 1'b0;
		step = 1'b0;
		rok = 1'b0;
		ren = 1'b0;
		repeat (5) @(negedge got);
		check("state", state, state_word'(1) << ST_P0);	// Reset values
		check("strob1", strob1, 0);
		check("strob2", strob2, 0);
		check("zg", zg, 0);
		check("awaria", awaria, 0);
		clo = 1'b0;
		for (int n = 0; n < N_RUN; n++) begin
			do @(negedge got); while (!strob2);
			@(negedge got);	// New state loaded, enter free to change
			mode = (n >= N_RUN / 2);	// Second half in step mode
			k = $unsigned($random(stim_seed)) % (N_STATES + 3);
			if (k >= N_STATES)
				enter = '0;
			else
				enter = (state_word'($random(stim_seed)) & ~((state_word'(1) << k) - 1'b1)) |
					(state_word'(1) << k);	// Bit k is the lowest request
		end
		do @(negedge got); while (!strob2);
		repeat (2) @(negedge got);
		$display("TESTBENCH PASSED");
		$finish;
	end

	initial begin : step_driver
		forever begin
			repeat ($unsigned($random(step_seed)) % 6 + 1) @(negedge got);
			step = 1'b1;	// One cycle pulse
			@(negedge got);
			step = 1'b0;
		end
	end

	// Answers zg with rok, ren or silence and tracks the bus cycle length
	initial begin : responder
		int delay;
		int pick;
		int tries;
		bit busy;
		forever begin
			@(negedge got);
			if (zg) begin
				tries = 0;
				busy = 1'b1;
				while (busy) begin
					pick = $unsigned($random(resp_seed)) % 4;	// 0,1 rok  2 ren  3 silent
					delay = $unsigned($random(resp_seed)) % 4;
					if (pick == 2 && tries == 2)
						pick = 0;	// Bound the retries
					check("awaria", awaria, alarm_exp);
					if (pick == 3) begin
						repeat (ALARM_TICKS - 1) begin
							@(negedge got);
							check("zg", zg, 1);
						end
						@(negedge got);
						check("zg", zg, 0);	// Timed out
						check("awaria", awaria, 1);
						alarm_exp = 1'b1;
						bus_extra += ALARM_TICKS + 1;
						busy = 1'b0;
					end else begin
						repeat (delay) begin
							@(negedge got);
							check("zg", zg, 1);
						end
						if (pick == 2)
							ren = 1'b1;
						else
							rok = 1'b1;
						@(negedge got);
						rok = 1'b0;
						ren = 1'b0;
						check("zg", zg, 0);	// Drops right after the answer
						bus_extra += delay + 2;
						if (pick == 2) begin
							repeat (RETRY_GAP - 1) begin
								@(negedge got);
								check("zg", zg, 0);
								bus_extra += 1;
							end
							@(negedge got);
							check("zg", zg, 1);	// Raised again after the gap
							tries++;
						end else begin
							busy = 1'b0;
						end
					end
				end
			end
		end
	end

	initial begin : compare
		int           offset;	// Cycles since last strob2
		int           exp_s1;
		int           cur_idx;
		logic         cur_bus;
		logic         cur_valid;
		logic         pending;	// State load to check
		logic         step_seen;
		logic [255:0] steps;	// Step pulses per cycle offset
		state_word    exp_state;
		offset = 0;
		exp_s1 = -1;
		cur_idx = 0;
		cur_bus = 1'b0;
		cur_valid = 1'b0;
		pending = 1'b0;
		steps = '0;
		forever begin
			@(posedge got);
			step_seen = step;
			@(negedge got);
			if (!clo) begin
				if (offset < 255)
					offset++;
				steps[offset - 1] = step_seen;
				if (alarm_exp)
					check("awaria", awaria, 1);	// Sticky
				if (cur_valid)
					check("zg outside bus state", zg && !cur_bus, 0);
				if (strob1) begin
					check("zg during strob1", zg, 0);
					if (cur_valid) begin
						check("bus cycle used", bus_extra != 0, cur_bus);
						exp_s1 = strob1_offset(cur_idx, bus_extra, mode, steps);
						check("strob1 offset", offset, exp_s1);
					end
				end
				if (strob2) begin
					if (cur_valid)
						check("strob2 offset", offset, exp_s1 + 1);
					exp_state = lowest_request(enter);
					pending = 1'b1;
					offset = 0;
					steps = '0;
					bus_extra = 0;
					exp_s1 = -1;	// strob1 must come again
					cur_valid = 1'b0;
				end else if (pending) begin
					check("state", state, exp_state);
					cur_idx = state_index(exp_state);
					cur_bus = |(exp_state & BUS_STATES);
					cur_valid = 1'b1;
					pending = 1'b0;
				end
			end
		end
	end

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("ERROR: run did not finish within %0d ns, the DUT stopped advancing",
			TIMEOUT_NS);
		$display("TESTBENCH FAILED");
		$fatal(1, "Timeout");
	end

endmodule

// ==== bench/px_clock_gen.sv ====
/* Testbench clock source, free-running got */
`timescale 1ns/1ps

module px_clock_gen #(
	parameter int PERIOD = 20	// ns
) (
	output logic got
);

	initial got = 1'b0;
	always #(PERIOD / 2) got = ~got;	// Half period per phase

endmodule

// ==== source/px_control.sv ====
/*
	P-X state control top
	State register, group delay timers, strobe sequencer and bus requester
*/
`timescale 1ns/1ps

module px_control
	import px_state_pkg::*;
(
	input  logic      got,
	input  logic      clo,
	input  state_word enter,	// Enter state requests
	input  logic      mode,	// Step mode
	input  logic      step,
	input  logic      rok,
	input  logic      ren,
	output state_word state,
	output logic      strob1,
	output logic      strob2,
	output logic      zg,
	output logic      awaria
);

	logic [N_GROUPS-1:0] group_start;
	logic [N_GROUPS-1:0] group_done;
	logic                bus_need;
	logic                bus_done;

	px_state_register u_register (
		.got         (got),
		.clo         (clo),
		.enter       (enter),
		.strob2      (strob2),
		.state       (state),
		.group_start (group_start)
	);

	// One timer per delay group, in place of the one-shots
	for (genvar g = 0; g < N_GROUPS; g++) begin : g_timer
		px_delay_timer #(
			.LENGTH (GROUP_LEN[g])
		) u_timer (
			.got   (got),
			.clo   (clo),
			.start (group_start[g]),
			.done  (group_done[g])
		);
	end

	px_strobe_sequencer u_sequencer (
		.got        (got),
		.clo        (clo),
		.group_done (group_done),
		.state      (state),
		.mode       (mode),
		.step       (step),
		.bus_done   (bus_done),
		.bus_need   (bus_need),
		.strob1     (strob1),
		.strob2     (strob2)
	);

	px_bus_requester u_requester (
		.got      (got),
		.clo      (clo),
		.bus_need (bus_need),
		.rok      (rok),
		.ren      (ren),
		.zg       (zg),
		.bus_done (bus_done),
		.awaria   (awaria)
	);

endmodule

// ==== source/px_bus_requester.sv ====
/*
	System bus requester
	Raises zg, retries on ren, completes on rok, alarms when nobody answers
*/
`timescale 1ns/1ps

module px_bus_requester
	import px_bus_pkg::*;
(
	input  logic got,
	input  logic clo,
	input  logic bus_need,	// Sequencer wants the bus
	input  logic rok,	// Request accepted
	input  logic ren,	// Bus engaged, retry
	output logic zg,	// Bus request
	output logic bus_done,	// Request finished, one cycle
	output logic awaria	// No-answer alarm, sticky
);

	logic [1:0]        phase;
	logic [GAP_W-1:0]  gap;	// Retry gap countdown
	logic [TICK_W-1:0] tick;	// Cycles zg has waited

	always_ff @(posedge got or posedge clo) begin
		if (clo) begin
			phase <= RQ_IDLE;
			gap <= '0;
			tick <= '0;
			awaria <= 1'b0;
		end else begin
			case (phase)
				RQ_IDLE: begin
					tick <= '0;
					if (bus_need)
						phase <= RQ_REQ;
				end
				RQ_REQ: begin
					tick <= tick + 1'b1;
					if (rok) begin
						phase <= RQ_ACK;	// Accepted
					end else if (ren) begin
						phase <= RQ_GAP;
						gap <= GAP_W'(RETRY_GAP - 1);
					end else if (tick == TICK_W'(ALARM_TICKS - 1)) begin
						phase <= RQ_ACK;	// Give up, let the state finish
						awaria <= 1'b1;
					end
				end
				RQ_GAP: begin
					tick <= '0;	// Fresh timeout per request
					if (gap == '0)
						phase <= RQ_REQ;	// Raise zg again
					else
						gap <= gap - 1'b1;
				end
				RQ_ACK: begin
					tick <= '0;
					phase <= RQ_IDLE;	// bus_need drops with this cycle
				end
				default: phase <= RQ_IDLE;
			endcase
		end
	end

	assign zg = (phase == RQ_REQ);
	assign bus_done = (phase == RQ_ACK);

endmodule

// ==== source/px_strobe_sequencer.sv ====
/*
	P-X strobe sequencer
	Waits for the state delay, bus cycle and step, then issues strob1 and strob2
*/
`timescale 1ns/1ps

module px_strobe_sequencer
	import px_state_pkg::*;
(
	input  logic                got,
	input  logic                clo,
	input  logic [N_GROUPS-1:0] group_done,	// Timer completions
	input  state_word           state,
	input  logic                mode,	// Step mode
	input  logic                step,	// Step pulse
	input  logic                bus_done,	// Bus cycle finished
	output logic                bus_need,	// Level, held until bus_done
	output logic                strob1,
	output logic                strob2
);

	logic [2:0] phase;
	logic       done_any;	// Any timer expired
	logic       is_bus;	// Current state uses the bus

	assign done_any = |group_done;
	assign is_bus = |(state & BUS_STATES);

	always_ff @(posedge got or posedge clo) begin
		if (clo) begin
			phase <= PH_WAIT_DELAY;
		end else begin
			case (phase)
				PH_WAIT_DELAY: begin
					if (done_any) begin
						if (is_bus)
							phase <= PH_WAIT_BUS;	// Bus first
						else if (mode)
							phase <= PH_WAIT_STEP;
						else
							phase <= PH_STROBE1;
					end
				end
				PH_WAIT_BUS: begin
					if (bus_done)
						phase <= mode ? PH_WAIT_STEP : PH_STROBE1;
				end
				PH_WAIT_STEP: begin
					if (step)
						phase <= PH_STROBE1;	// One state per step
				end
				PH_STROBE1: phase <= PH_STROBE2;
				PH_STROBE2: phase <= PH_WAIT_DELAY;	// New state loads here
				default: phase <= PH_WAIT_DELAY;
			endcase
		end
	end

	// Raised with done so zg follows one cycle later
	assign bus_need = (phase == PH_WAIT_BUS) ||
		((phase == PH_WAIT_DELAY) && done_any && is_bus);

	assign strob1 = (phase == PH_STROBE1);
	assign strob2 = (phase == PH_STROBE2);

endmodule

// ==== source/px_delay_timer.sv ====
/*
	Counting state delay
	Replaces one 74123 one-shot, done pulses LENGTH cycles after the start cycle
*/
`timescale 1ns/1ps

module px_delay_timer #(
	parameter int LENGTH = 1	// Delay in got cycles, at least 1
) (
	input  logic got,
	input  logic clo,
	input  logic start,	// Trigger, one cycle
	output logic done	// End of delay, one cycle
);

	localparam int CNT_W = $clog2(LENGTH + 1);

	logic [CNT_W-1:0] cnt;	// Remaining cycles

	always_ff @(posedge got or posedge clo) begin
		if (clo) begin
			cnt <= '0;
			done <= 1'b0;
		end else if (start) begin
			cnt <= CNT_W'(LENGTH - 1);	// Retrigger restarts the delay
			done <= (LENGTH == 1);	// Shortest delay ends at once
		end else if (cnt != '0) begin
			cnt <= cnt - 1'b1;
			done <= (cnt == CNT_W'(1));	// Last count
		end else begin
			done <= 1'b0;
		end
	end

endmodule

// ==== source/px_state_register.sv ====
/*
	P-X state register
	One-hot processor state, next state selection and delay group start pulses
*/
`timescale 1ns/1ps

module px_state_register
	import px_state_pkg::*;
(
	input  logic                got,
	input  logic                clo,
	input  state_word           enter,	// Enter requests, lowest wins
	input  logic                strob2,	// Advance strobe
	output state_word           state,
	output logic [N_GROUPS-1:0] group_start	// One pulse per entered state
);

	state_word lowest;	// Lowest requested state
	state_word next_state;
	logic      new_state;	// State was just loaded

	// Isolate lowest set bit of the request vector
	assign lowest = enter & (~enter + state_word'(1));

	always_comb begin
		if (lowest == '0)
			next_state = state_word'(1) << ST_P0;	// Nothing requested, back to P0
		else
			next_state = lowest;
	end

	always_ff @(posedge got or posedge clo) begin
		if (clo) begin
			state <= state_word'(1) << ST_P0;	// Power-up in P0
			new_state <= 1'b1;	// Kick P0's timer after reset
		end else begin
			new_state <= strob2;
			if (strob2)
				state <= next_state;
		end
	end

	// Route the new state to its group's timer
	always_comb begin
		group_start = '0;
		for (int i = 0; i < N_STATES; i++) begin
			if (new_state && state[i])
				group_start[STATE_GROUP[i]] = 1'b1;
		end
	end

endmodule

// ==== source/px_bus_pkg.sv ====
/*
	System bus request timing
	Retry gap after an engaged answer and the no-answer alarm timeout
*/

package px_bus_pkg;

	localparam int RETRY_GAP = 2;	// zg low cycles after ren
	localparam int ALARM_TICKS = 12;	// Max zg high cycles without answer

	localparam int GAP_W = $clog2(RETRY_GAP + 1);	// Retry gap counter width
	localparam int TICK_W = $clog2(ALARM_TICKS + 1);	// Timeout counter width

	// Requester phases
	localparam logic [1:0] RQ_IDLE = 2'd0;
	localparam logic [1:0] RQ_REQ = 2'd1;	// zg raised
	localparam logic [1:0] RQ_GAP = 2'd2;	// Backing off after ren
	localparam logic [1:0] RQ_ACK = 2'd3;	// bus_done cycle

endpackage

// ==== source/px_state_pkg.sv ====
/*
	P-X state control definitions
	State bit positions, delay groups and the states that use the system bus
*/

package px_state_pkg;

	localparam int N_STATES = 16;	// One bit per processor state
	localparam int N_GROUPS = 5;	// Delay groups, one timer each

	typedef logic [N_STATES-1:0] state_word;	// Current state and enter requests

	localparam int ST_P0 = 0;
	localparam int ST_P1 = 1;
	localparam int ST_P2 = 2;
	localparam int ST_P3 = 3;
	localparam int ST_P4 = 4;
	localparam int ST_P5 = 5;
	localparam int ST_K1 = 6;
	localparam int ST_K2 = 7;
	localparam int ST_WP = 8;
	localparam int ST_WA = 9;
	localparam int ST_WZ = 10;
	localparam int ST_WX = 11;
	localparam int ST_WR = 12;
	localparam int ST_WE = 13;
	localparam int ST_WW = 14;
	localparam int ST_WM = 15;

	// Delay group of each state, indexed P0..WM
	localparam int STATE_GROUP [N_STATES] = '{3, 1, 4, 3, 0, 2, 1, 1, 4, 3, 3, 4, 2, 0, 2, 2};

	localparam int GROUP_LEN [N_GROUPS] = '{2, 5, 3, 1, 2};	// Cycles per group

	// States that fetch or store over the system bus
	localparam state_word BUS_STATES = state_word'((1 << ST_P1) | (1 << ST_K1) |
		(1 << ST_K2) | (1 << ST_P5) | (1 << ST_WR) | (1 << ST_WW) | (1 << ST_WM));

	// Strobe sequencer phases
	localparam logic [2:0] PH_WAIT_DELAY = 3'd0;	// Timer running
	localparam logic [2:0] PH_WAIT_BUS = 3'd1;	// Bus cycle pending
	localparam logic [2:0] PH_WAIT_STEP = 3'd2;	// Held for step pulse
	localparam logic [2:0] PH_STROBE1 = 3'd3;
	localparam logic [2:0] PH_STROBE2 = 3'd4;

endpackage
